/* source/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// fetch address loaded on reset, the MIPS boot ROM entry.
`define FETCH_RESET_VECTOR 32'hbfc00000

// branch prediction buffer geometry, entries must stay a power of two.
`define FETCH_BPB_ENTRIES 16
`define FETCH_BPB_INDEX_BITS 4

// width of one instruction or address word.
`define FETCH_DATA_WIDTH 32

`endif

/* source/fetch_pkg.sv */
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    typedef logic [`FETCH_DATA_WIDTH-1:0] word_t;

    // commit side view of a control transfer.
    typedef struct packed {
        logic  exception_valid;
        logic  is_eret;
        logic  branch;
        logic  jump;
        logic  jr;
        word_t pcexception;
        word_t epc;
        word_t pcbranch;
        word_t pcjump;
        word_t pcjr;
    } redirect_t;

    typedef struct packed {
        logic  taken;
        word_t destpc;
    } bpb_result_t;

    typedef struct packed {
        word_t instr;
        word_t pcplus4;
        logic  en;
        logic  exception_instr;
        logic  pred;
        logic  is_branch;
    } fetch_data_t;

    // one instruction word, seen as i-type or j-type.
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] immediate;
        } i_form;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j_form;
    } instr_t;

endpackage

`default_nettype wire

/* source/redirect_select.sv */
`timescale 1ns/1ps
`default_nettype none

module redirect_select
    import fetch_pkg::*;
(
    input  redirect_t redirect,
    output word_t     redirect_pc,
    output logic      redirect_strobe
);

    assign redirect_strobe = redirect.exception_valid | redirect.is_eret |
                             redirect.branch | redirect.jump | redirect.jr;

    // exception beats everything, jr is the weakest.
    always_comb
    begin
        if (redirect.exception_valid)
            redirect_pc = redirect.pcexception;
        else if (redirect.is_eret)
            redirect_pc = redirect.epc;
        else if (redirect.branch)
            redirect_pc = redirect.pcbranch;
        else if (redirect.jump)
            redirect_pc = redirect.pcjump;
        else
            redirect_pc = redirect.pcjr;  // also the idle value, unused without strobe.
    end

    // the exception vector must be a real instruction address.
    always_comb
    begin
        if (redirect_strobe && redirect.exception_valid)
        begin
            assert (redirect_pc[1:0] == 2'b00)
                else $error("exception redirect to misaligned pc %h", redirect_pc);
        end
    end

endmodule

`default_nettype wire

/* source/branch_predict_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module branch_predict_buffer
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  word_t       [1:0] lookup_pc,
    output bpb_result_t [1:0] lookup_result,
    input  logic              update_valid,
    input  word_t             update_pc,
    input  logic              update_taken,
    input  word_t             update_target
);

    localparam int INDEX_BITS = `FETCH_BPB_INDEX_BITS;
    localparam int ENTRIES    = `FETCH_BPB_ENTRIES;
    localparam int TAG_BITS   = `FETCH_DATA_WIDTH - INDEX_BITS - 2;

    logic [ENTRIES-1:0]  entry_valid;
    logic [TAG_BITS-1:0] entry_tag    [ENTRIES];
    logic                entry_taken  [ENTRIES];
    word_t               entry_target [ENTRIES];

    logic [INDEX_BITS-1:0] update_index;
    logic [TAG_BITS-1:0]   update_tag;

    assign update_index = update_pc[INDEX_BITS+1:2];
    assign update_tag   = update_pc[`FETCH_DATA_WIDTH-1:INDEX_BITS+2];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            entry_valid <= '0;
        else if (update_valid)
            entry_valid[update_index] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (update_valid)
        begin
            entry_tag[update_index]    <= update_tag;
            entry_taken[update_index]  <= update_taken;
            entry_target[update_index] <= update_target;
        end
    end

    // two read ports, one per fetch slot.
    for (genvar i = 0; i < 2; i++)
    begin : g_lookup
        logic [INDEX_BITS-1:0] index;
        logic [TAG_BITS-1:0]   tag;
        logic                  match;

        assign index = lookup_pc[i][INDEX_BITS+1:2];
        assign tag   = lookup_pc[i][`FETCH_DATA_WIDTH-1:INDEX_BITS+2];
        assign match = entry_valid[index] && (entry_tag[index] == tag);

        always_comb
        begin
            if (match)
            begin
                lookup_result[i].taken  = entry_taken[index];
                lookup_result[i].destpc = entry_target[index];
            end
            else
                lookup_result[i] = '0;  // a miss reads as not taken.
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        update_valid |-> (update_pc[1:0] == 2'b00))
        else $error("branch buffer trained with misaligned pc %h", update_pc);

endmodule

`default_nettype wire

/* source/fetch_pc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_pc
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  word_t             redirect_pc,
    input  logic              redirect_strobe,
    input  logic              hit,
    input  logic              data_ok,
    input  bpb_result_t [1:0] slot_predict,
    output word_t             pc,
    output word_t       [1:0] slot_pc,
    output logic              carried_taken,
    output logic              finish
);

    bpb_result_t carried;
    bpb_result_t carried_next;
    logic        conflict;
    logic        advance;
    word_t       pc_plus4;
    word_t       pc_plus8;
    word_t       pc_seq;

    assign pc_plus4 = pc + 32'd4;
    assign pc_plus8 = pc + 32'd8;

    assign slot_pc[1] = pc;
    assign slot_pc[0] = pc_plus4;

    // an answer still in flight after a redirect belongs to the old pc.
    assign finish  = data_ok && !conflict;
    assign advance = finish && !stall;

    assign carried_taken = carried.taken;

    always_comb
    begin
        if (carried.taken)
            pc_seq = carried.destpc;  // delay slot already fetched.
        else if (hit && slot_predict[1].taken)
            pc_seq = slot_predict[1].destpc;
        else if (hit)
            pc_seq = pc_plus8;
        else
            pc_seq = pc_plus4;
    end

    // the last slot fetched decides what gets carried.
    assign carried_next = hit ? slot_predict[0] : slot_predict[1];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pc      <= `FETCH_RESET_VECTOR;
            carried <= '0;
        end
        else if (redirect_strobe)
        begin
            pc      <= redirect_pc;
            carried <= '0;
        end
        else if (advance)
        begin
            pc      <= pc_seq;
            carried <= carried_next;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            conflict <= 1'b0;
        else if (data_ok)
            conflict <= 1'b0;  // a returning answer retires the old request.
        else if (redirect_strobe)
            conflict <= 1'b1;
    end

    assert property (@(posedge clk) disable iff (reset)
        (stall && !redirect_strobe) |=> $stable(pc))
        else $error("pc moved during stall");

endmodule

`default_nettype wire

/* source/fetch_pack.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pack
    import fetch_pkg::*;
(
    input  word_t             pc,
    input  word_t       [1:0] data,
    input  logic              hit,
    input  logic              carried_taken,
    input  bpb_result_t [1:0] slot_predict,
    output fetch_data_t [1:0] fetch_data
);

    instr_t [1:0] slot_instr;
    logic         misaligned;

    // opcodes 1 and 4..7 are branches, 2 and 3 are j and jal.
    function automatic logic is_control(input instr_t ins);
        logic branch_op;
        logic jump_op;
        branch_op = (ins.i_form.opcode == 6'd1) ||
                    (ins.i_form.opcode >= 6'd4 && ins.i_form.opcode <= 6'd7);
        jump_op   = (ins.j_form.opcode == 6'd2) || (ins.j_form.opcode == 6'd3);
        return branch_op || jump_op;
    endfunction

    assign slot_instr[1] = data[0];
    assign slot_instr[0] = carried_taken ? '0 : data[1];  // squashed behind a taken delay slot.

    assign misaligned = (pc[1:0] != 2'b00);

    always_comb
    begin
        fetch_data[1].instr           = slot_instr[1];
        fetch_data[1].pcplus4         = pc + 32'd4;
        fetch_data[1].en              = 1'b1;
        fetch_data[1].exception_instr = misaligned;
        fetch_data[1].pred            = slot_predict[1].taken;
        fetch_data[1].is_branch       = is_control(slot_instr[1]);
    end

    always_comb
    begin
        fetch_data[0].instr           = slot_instr[0];
        fetch_data[0].pcplus4         = pc + 32'd8;
        fetch_data[0].en              = hit && !carried_taken;
        fetch_data[0].exception_instr = misaligned;
        fetch_data[0].pred            = slot_predict[0].taken && hit;
        fetch_data[0].is_branch       = is_control(slot_instr[0]);
    end

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  redirect_t         redirect,
    input  logic              update_valid,
    input  word_t             update_pc,
    input  logic              update_taken,
    input  word_t             update_target,
    output word_t             addr,
    input  word_t       [1:0] data,
    input  logic              hit,
    input  logic              data_ok,
    output fetch_data_t [1:0] fetch_data,
    output logic              finish,
    output word_t       [1:0] pc_predict
);

    word_t             redirect_pc;
    logic              redirect_strobe;
    word_t             pc;
    word_t       [1:0] slot_pc;
    logic              carried_taken;
    bpb_result_t [1:0] slot_predict;

    redirect_select u_redirect_select (
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .redirect_strobe (redirect_strobe)
    );

    branch_predict_buffer u_bpb (
        .clk           (clk),
        .reset         (reset),
        .lookup_pc     (slot_pc),
        .lookup_result (slot_predict),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target)
    );

    fetch_pc u_fetch_pc (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .redirect_pc     (redirect_pc),
        .redirect_strobe (redirect_strobe),
        .hit             (hit),
        .data_ok         (data_ok),
        .slot_predict    (slot_predict),
        .pc              (pc),
        .slot_pc         (slot_pc),
        .carried_taken   (carried_taken),
        .finish          (finish)
    );

    fetch_pack u_fetch_pack (
        .pc            (pc),
        .data          (data),
        .hit           (hit),
        .carried_taken (carried_taken),
        .slot_predict  (slot_predict),
        .fetch_data    (fetch_data)
    );

    assign addr       = pc;
    assign pc_predict = slot_pc;  // slot 1 is pc, slot 0 is pc+4.

endmodule

`default_nettype wire

/* testbench/tb_fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module tb_fetch_unit
    import fetch_pkg::*;
;

    typedef struct packed {
        logic       stall;
        logic [4:0] flags;  // exception, eret, branch, jump, jr.
        word_t      base;
        logic       train;
        word_t      train_pc;
        word_t      train_target;
        logic       hit;
        word_t      next_pc;
    } row_t;

    logic              clk;
    logic              reset;
    logic              stall;
    redirect_t         redirect;
    logic              update_valid;
    word_t             update_pc;
    logic              update_taken;
    word_t             update_target;
    word_t             addr;
    word_t       [1:0] data;
    logic              hit;
    logic              data_ok;
    fetch_data_t [1:0] fetch_data;
    logic              finish;
    word_t       [1:0] pc_predict;

    row_t  rows [$];
    word_t salt [64];
    logic  model_valid [`FETCH_BPB_ENTRIES];
    word_t model_pc    [`FETCH_BPB_ENTRIES];
    word_t cur_pc;
    logic  carried_m;

    fetch_unit dut (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .redirect      (redirect),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target),
        .addr          (addr),
        .data          (data),
        .hit           (hit),
        .data_ok       (data_ok),
        .fetch_data    (fetch_data),
        .finish        (finish),
        .pc_predict    (pc_predict)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t mem_word(input word_t a);
        return salt[a[7:2]] ^ {6'd0, a[31:8], a[1:0]};
    endfunction

    // opcodes 1 to 7 are the branch and jump group.
    function automatic logic control_op(input word_t w);
        return (w[31:26] >= 6'd1) && (w[31:26] <= 6'd7);
    endfunction

    function automatic logic predicted_taken(input word_t a);
        logic [`FETCH_BPB_INDEX_BITS-1:0] idx;
        idx = a[`FETCH_BPB_INDEX_BITS+1:2];
        return model_valid[idx] && (model_pc[idx][31:2] == a[31:2]);
    endfunction

    function automatic void add_row(input logic stall_in, input logic [4:0] flags,
                                    input word_t base, input logic train, input word_t train_pc,
                                    input word_t train_target, input logic hit_in,
                                    input word_t next_pc);
        row_t r;
        r.stall        = stall_in;
        r.flags        = flags;
        r.base         = base;
        r.train        = train;
        r.train_pc     = train_pc;
        r.train_target = train_target;
        r.hit          = hit_in;
        r.next_pc      = next_pc;
        rows.push_back(r);
    endfunction

    function automatic void fetch_row(input logic stall_in, input logic hit_in, input word_t next_pc);
        add_row(stall_in, 5'b00000, 32'h0, 1'b0, 32'h0, 32'h0, hit_in, next_pc);
    endfunction

    function automatic void redirect_row(input logic [4:0] flags, input word_t base,
                                         input word_t next_pc);
        add_row(1'b0, flags, base, 1'b0, 32'h0, 32'h0, 1'b1, next_pc);
    endfunction

    function automatic void train_row(input word_t pc_in, input word_t target, input word_t next_pc);
        add_row(1'b0, 5'b00000, 32'h0, 1'b1, pc_in, target, 1'b1, next_pc);
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected)
            fail_run($sformatf("FAILED %s: got %h, expected %h", name, actual, expected));
    endtask

    task automatic wait_data_ok();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!data_ok && cycles < 20)
        begin
            cycles++;
            @(negedge clk);
        end
        if (!data_ok)
            fail_run("timeout: the memory gave no answer within 20 cycles");
    endtask

    task automatic check_records(input logic hit_now);
        word_t instr0;
        logic  misaligned;
        misaligned = (cur_pc[1:0] != 2'b00);
        instr0 = carried_m ? 32'h0 : mem_word(cur_pc + 32'd4);  // squashed after a taken slot.
        check_value("addr", addr, cur_pc);
        check_value("finish", 32'(finish), 32'd1);
        check_value("pc_predict[1]", pc_predict[1], cur_pc);
        check_value("pc_predict[0]", pc_predict[0], cur_pc + 32'd4);
        check_value("fetch_data[1].instr", fetch_data[1].instr, mem_word(cur_pc));
        check_value("fetch_data[1].pcplus4", fetch_data[1].pcplus4, cur_pc + 32'd4);
        check_value("fetch_data[1].en", 32'(fetch_data[1].en), 32'd1);
        check_value("fetch_data[1].exception_instr", 32'(fetch_data[1].exception_instr),
                    32'(misaligned));
        check_value("fetch_data[1].pred", 32'(fetch_data[1].pred), 32'(predicted_taken(cur_pc)));
        check_value("fetch_data[1].is_branch", 32'(fetch_data[1].is_branch),
                    32'(control_op(mem_word(cur_pc))));
        check_value("fetch_data[0].instr", fetch_data[0].instr, instr0);
        check_value("fetch_data[0].pcplus4", fetch_data[0].pcplus4, cur_pc + 32'd8);
        check_value("fetch_data[0].en", 32'(fetch_data[0].en), 32'(hit_now && !carried_m));
        check_value("fetch_data[0].exception_instr", 32'(fetch_data[0].exception_instr),
                    32'(misaligned));
        check_value("fetch_data[0].pred", 32'(fetch_data[0].pred),
                    32'(hit_now && predicted_taken(cur_pc + 32'd4)));
        check_value("fetch_data[0].is_branch", 32'(fetch_data[0].is_branch),
                    32'(control_op(instr0)));
    endtask

    // memory model, at least two idle cycles between answers.
    initial
    begin
        int gap;
        data_ok = 1'b0;
        data[0] = 32'h0;
        data[1] = 32'h0;
        gap = 2;
        forever
        begin
            @(posedge clk);
            if (reset)
            begin
                data_ok <= 1'b0;
                gap = 2;
            end
            else if (data_ok)
            begin
                data_ok <= 1'b0;
                gap = 1 + int'($urandom % 3);
            end
            else if (gap == 0)
            begin
                data_ok <= 1'b1;
                data[0] <= mem_word(addr);
                data[1] <= mem_word(addr + 32'd4);
            end
            else
                gap = gap - 1;
        end
    end

    initial
    begin
        row_t                             row;
        logic [`FETCH_BPB_INDEX_BITS-1:0] idx;
        reset         = 1'b1;
        stall         = 1'b0;
        hit           = 1'b0;
        redirect      = '0;
        update_valid  = 1'b0;
        update_pc     = 32'h0;
        update_taken  = 1'b0;
        update_target = 32'h0;
        void'($urandom(32'h2de8e65b));
        for (int i = 0; i < 64; i++)
        begin
            salt[i] = $urandom;
            if (i < 8)
                salt[i][31:26] = 6'(i);  // first lines walk through the control opcodes.
        end
        for (int i = 0; i < `FETCH_BPB_ENTRIES; i++)
            model_valid[i] = 1'b0;

        fetch_row(1'b0, 1'b1, 32'hbfc00008);
        fetch_row(1'b0, 1'b0, 32'hbfc0000c);
        fetch_row(1'b0, 1'b1, 32'hbfc00014);
        fetch_row(1'b1, 1'b1, 32'hbfc00014);  // decode holds fetch.
        fetch_row(1'b1, 1'b0, 32'hbfc00014);
        fetch_row(1'b1, 1'b1, 32'hbfc00014);
        fetch_row(1'b0, 1'b0, 32'hbfc00018);
        redirect_row(5'b10101, 32'h80000000, 32'h80000000);
        redirect_row(5'b01110, 32'h80001000, 32'h80001100);
        redirect_row(5'b00101, 32'h80002000, 32'h80002200);
        redirect_row(5'b00011, 32'h80003000, 32'h80003300);
        fetch_row(1'b0, 1'b1, 32'h80003308);
        train_row(32'h80003310, 32'h80004000, 32'h80003310);
        fetch_row(1'b0, 1'b1, 32'h80004000);  // slot 1 taken.
        train_row(32'h80004014, 32'h80005000, 32'h80004008);
        fetch_row(1'b0, 1'b1, 32'h80004010);
        fetch_row(1'b0, 1'b1, 32'h80004018);  // slot 0 taken, carried over.
        fetch_row(1'b0, 1'b1, 32'h80005000);
        redirect_row(5'b00001, 32'h80006002, 32'h80006402);
        fetch_row(1'b0, 1'b1, 32'h8000640a);
        fetch_row(1'b0, 1'b0, 32'h8000640e);
        redirect_row(5'b10000, 32'hbfc00380, 32'hbfc00380);
        fetch_row(1'b0, 1'b1, 32'hbfc00388);
        fetch_row(1'b0, 1'b0, 32'hbfc0038c);
        fetch_row(1'b0, 1'b1, 32'hbfc00394);
        fetch_row(1'b1, 1'b1, 32'hbfc00394);
        fetch_row(1'b0, 1'b1, 32'hbfc0039c);

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("addr", addr, `FETCH_RESET_VECTOR);
        check_value("finish", 32'(finish), 32'd0);
        cur_pc    = `FETCH_RESET_VECTOR;
        carried_m = 1'b0;

        for (int r = 0; r < rows.size(); r++)
        begin
            row = rows[r];
            @(posedge clk);
            stall                     <= row.stall;
            hit                       <= row.hit;
            redirect.exception_valid  <= row.flags[4];
            redirect.is_eret          <= row.flags[3];
            redirect.branch           <= row.flags[2];
            redirect.jump             <= row.flags[1];
            redirect.jr               <= row.flags[0];
            redirect.pcexception      <= row.base;
            redirect.epc              <= row.base + 32'h100;
            redirect.pcbranch         <= row.base + 32'h200;
            redirect.pcjump           <= row.base + 32'h300;
            redirect.pcjr             <= row.base + 32'h400;
            update_valid              <= row.train;
            update_pc                 <= row.train_pc;
            update_taken              <= row.train;
            update_target             <= row.train_target;
            if (row.train)
            begin
                idx = row.train_pc[`FETCH_BPB_INDEX_BITS+1:2];
                model_valid[idx] = 1'b1;
                model_pc[idx]    = row.train_pc;
            end
            @(posedge clk);
            redirect.exception_valid <= 1'b0;
            redirect.is_eret         <= 1'b0;
            redirect.branch          <= 1'b0;
            redirect.jump            <= 1'b0;
            redirect.jr              <= 1'b0;
            update_valid             <= 1'b0;
            wait_data_ok();
            if (row.flags != 5'b00000)
            begin
                check_value("finish", 32'(finish), 32'd0);  // answer for the old address.
                carried_m = 1'b0;
            end
            else
            begin
                check_records(row.hit);
                if (!row.stall)
                    carried_m = row.hit ? predicted_taken(cur_pc + 32'd4) : predicted_taken(cur_pc);
            end
            @(posedge clk);
            @(negedge clk);
            check_value("addr", addr, row.next_pc);
            cur_pc = row.next_pc;
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+source
source/fetch_pkg.sv
source/redirect_select.sv
source/branch_predict_buffer.sv
source/fetch_pc.sv
source/fetch_pack.sv
source/fetch_unit.sv
testbench/tb_fetch_unit.sv

/* run.sh */
#!/usr/bin/env bash
# Build the fetch unit testbench with Verilator, run it and scan the log.

set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log
rm -rf obj_dir "$log_file"

verilator --binary --timing --assert -f list.f --top-module tb_fetch_unit -o tb_fetch_unit
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_fetch_unit > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "Verification passed" "$log_file"; then
    exit 0
else
    echo "pass message not found in $log_file"
    exit 1
fi
